// ==== hdl/proc_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module proc_ctrl (
  input  wire                  clk,
  input  wire                  reset,
  input  wire tinyrv1_pkg::status_t status,
  output tinyrv1_pkg::ctrl_t   ctrl
);
  import tinyrv1_pkg::*;

  word_t     inst_x;
  word_t     inst_m;
  word_t     inst_w;
  logic      val_d;
  logic      val_x;
  logic      val_m;
  logic      val_w;
  op_e       op_d;
  op_e       op_x;
  op_e       op_m;
  op_e       op_w;
  reg_addr_t rs1_d;
  reg_addr_t rs2_d;
  reg_addr_t rd_x;
  reg_addr_t rd_m;
  reg_addr_t rd_w;
  logic      use1_d;
  logic      use2_d;
  logic      wr_x;
  logic      wr_m;
  logic      wr_w;
  logic      wen_w;
  logic      stall;
  logic      br_taken;
  logic      jump_d;
  byp_sel_e  op1_byp;
  byp_sel_e  op2_byp;

  function automatic logic reads_rs1(op_e op);
    return op inside {OP_ADD, OP_ADDI, OP_MUL, OP_LW, OP_SW, OP_JR, OP_BNE};
  endfunction

  function automatic logic reads_rs2(op_e op);
    return op inside {OP_ADD, OP_MUL, OP_SW, OP_BNE};
  endfunction

  function automatic logic writes_rd(op_e op);
    return op inside {OP_ADD, OP_ADDI, OP_MUL, OP_LW, OP_JAL};
  endfunction

  // ==============================
  // Stage tracking
  // ==============================

  always_ff @(posedge clk) begin
    if (reset) begin
      val_x <= 1'b0;
      val_m <= 1'b0;
      val_w <= 1'b0;
    end else begin
      val_x <= val_d && !stall && !br_taken;  // Bubble on stall or branch
      val_m <= val_x;
      val_w <= val_m;
    end
  end

  always_ff @(posedge clk) begin
    inst_x <= status.inst_d;
    inst_m <= inst_x;
    inst_w <= inst_m;
  end

  assign op_d  = decode_op(status.inst_d);
  assign op_x  = decode_op(inst_x);
  assign op_m  = decode_op(inst_m);
  assign op_w  = decode_op(inst_w);
  assign val_d = (op_d != OP_NOP);  // Squashed words arrive as zero

  assign rs1_d = rs1_of(status.inst_d);
  assign rs2_d = rs2_of(status.inst_d);
  assign rd_x  = rd_of(inst_x);
  assign rd_m  = rd_of(inst_m);
  assign rd_w  = rd_of(inst_w);

  // ==============================
  // Hazards
  // ==============================

  assign use1_d = val_d && reads_rs1(op_d);
  assign use2_d = val_d && reads_rs2(op_d);
  assign wr_x   = val_x && writes_rd(op_x) && (rd_x != '0);
  assign wr_m   = val_m && writes_rd(op_m) && (rd_m != '0);
  assign wen_w  = val_w && writes_rd(op_w);
  assign wr_w   = wen_w && (rd_w != '0);

  // Youngest producer wins
  always_comb begin
    op1_byp = BYP_RF;
    if (use1_d && wr_w && rd_w == rs1_d) op1_byp = BYP_W;
    if (use1_d && wr_m && rd_m == rs1_d) op1_byp = BYP_M;
    if (use1_d && wr_x && rd_x == rs1_d && op_x != OP_LW) op1_byp = BYP_X;
    op2_byp = BYP_RF;
    if (use2_d && wr_w && rd_w == rs2_d) op2_byp = BYP_W;
    if (use2_d && wr_m && rd_m == rs2_d) op2_byp = BYP_M;
    if (use2_d && wr_x && rd_x == rs2_d && op_x != OP_LW) op2_byp = BYP_X;
  end

  // Load data only exists from M onward
  assign stall = wr_x && (op_x == OP_LW) &&
                 ((use1_d && rd_x == rs1_d) || (use2_d && rd_x == rs2_d));

  assign br_taken = val_x && (op_x == OP_BNE) && !status.eq_x;
  assign jump_d   = val_d && (op_d inside {OP_JAL, OP_JR}) && !stall;

  // ==============================
  // Per-stage control
  // ==============================

  always_comb begin
    ctrl          = '0;
    ctrl.reg_en_f = !stall;
    ctrl.reg_en_d = !stall;
    ctrl.squash_d = br_taken || jump_d;

    if (br_taken)                    ctrl.pc_sel = PC_BR;  // Older redirect first
    else if (jump_d && op_d == OP_JAL) ctrl.pc_sel = PC_JAL;
    else if (jump_d)                 ctrl.pc_sel = PC_JR;
    else                             ctrl.pc_sel = PC_PLUS4;

    ctrl.op1_byp  = op1_byp;
    ctrl.op2_byp  = op2_byp;
    ctrl.imm_type = IMM_I;
    if (val_d) begin
      case (op_d)
        OP_SW:   ctrl.imm_type = IMM_S;
        OP_JAL:  ctrl.imm_type = IMM_J;
        OP_BNE:  ctrl.imm_type = IMM_B;
        default: ctrl.imm_type = IMM_I;
      endcase
      ctrl.op2_imm = op_d inside {OP_ADDI, OP_LW, OP_SW};
    end

    ctrl.mul_sel  = val_x && (op_x == OP_MUL);
    ctrl.dmem_val = val_m && (op_m inside {OP_LW, OP_SW});
    ctrl.dmem_wr  = val_m && (op_m == OP_SW);
    ctrl.wb_mem   = val_m && (op_m == OP_LW);
    ctrl.rf_wen   = wen_w;  // x0 writes reach the register file and die there
    ctrl.rf_waddr = rd_w;
  end

  // A load sitting in X must never feed D directly
  no_x_byp_on_load: assert property (@(posedge clk) disable iff (reset)
    (val_x && op_x == OP_LW) |-> (ctrl.op1_byp != BYP_X && ctrl.op2_byp != BYP_X));

  // Redirects and load-use stalls are mutually exclusive
  no_stall_on_squash: assert property (@(posedge clk) disable iff (reset)
    ctrl.squash_d |-> !stall);

endmodule

`default_nettype wire

// ==== hdl/proc_dpath.sv ====
`timescale 1ns/100ps
`default_nettype none

module proc_dpath #(
  parameter tinyrv1_pkg::word_t RESET_PC = 32'h0000_0200
) (
  input  wire                         clk,
  input  wire                         reset,
  input  wire tinyrv1_pkg::ctrl_t     ctrl,
  output tinyrv1_pkg::status_t        status,
  output tinyrv1_pkg::word_t          imem_addr,
  input  wire tinyrv1_pkg::word_t     imem_data,
  output tinyrv1_pkg::dmem_req_t      dmem_req,
  input  wire tinyrv1_pkg::word_t     dmem_rdata,
  output tinyrv1_pkg::reg_addr_t      rf_raddr1,
  output tinyrv1_pkg::reg_addr_t      rf_raddr2,
  input  wire tinyrv1_pkg::word_t     rf_rdata1,
  input  wire tinyrv1_pkg::word_t     rf_rdata2,
  output logic                        rf_wen,
  output tinyrv1_pkg::reg_addr_t      rf_waddr,
  output tinyrv1_pkg::word_t          rf_wdata
);
  import tinyrv1_pkg::*;

  word_t pc_f;
  word_t pc_next;
  word_t inst_d;
  word_t pc_d;
  word_t imm_d;
  word_t targ_d;
  word_t op1_d;
  word_t op2_d;
  word_t op1_x;
  word_t op2_x;
  word_t sdata_x;
  word_t targ_x;
  word_t result_x;
  word_t result_m;
  word_t sdata_m;
  word_t wb_m;
  word_t wb_w;

  // ==============================
  // Fetch
  // ==============================

  always_comb begin
    case (ctrl.pc_sel)
      PC_JAL:  pc_next = targ_d;
      PC_JR:   pc_next = op1_d;   // Bypassed rs1
      PC_BR:   pc_next = targ_x;
      default: pc_next = pc_f + 32'd4;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) pc_f <= RESET_PC;
    else if (ctrl.reg_en_f) pc_f <= pc_next;
  end

  assign imem_addr = pc_f;

  // Zero in inst_d marks a bubble
  always_ff @(posedge clk) begin
    if (reset) inst_d <= '0;
    else if (ctrl.reg_en_d) inst_d <= ctrl.squash_d ? '0 : imem_data;
  end

  always_ff @(posedge clk) begin
    if (ctrl.reg_en_d) pc_d <= pc_f;
  end

  // ==============================
  // Decode
  // ==============================

  assign rf_raddr1 = rs1_of(inst_d);
  assign rf_raddr2 = rs2_of(inst_d);

  always_comb begin
    case (ctrl.imm_type)
      IMM_S:   imm_d = {{20{inst_d[31]}}, inst_d[31:25], inst_d[11:7]};
      IMM_J:   imm_d = {{12{inst_d[31]}}, inst_d[19:12], inst_d[20], inst_d[30:21], 1'b0};
      IMM_B:   imm_d = {{20{inst_d[31]}}, inst_d[7], inst_d[30:25], inst_d[11:8], 1'b0};
      default: imm_d = {{20{inst_d[31]}}, inst_d[31:20]};
    endcase
  end

  assign targ_d = pc_d + imm_d;  // JAL target now, BNE target in X

  always_comb begin
    case (ctrl.op1_byp)
      BYP_X:   op1_d = result_x;
      BYP_M:   op1_d = wb_m;
      BYP_W:   op1_d = wb_w;
      default: op1_d = rf_rdata1;
    endcase
    case (ctrl.op2_byp)
      BYP_X:   op2_d = result_x;
      BYP_M:   op2_d = wb_m;
      BYP_W:   op2_d = wb_w;
      default: op2_d = rf_rdata2;
    endcase
  end

  always_ff @(posedge clk) begin
    if (ctrl.pc_sel == PC_JAL) begin  // Link value PC+4 rides the X adder
      op1_x <= pc_d;
      op2_x <= 32'd4;
    end else begin
      op1_x <= op1_d;
      op2_x <= ctrl.op2_imm ? imm_d : op2_d;
    end
    sdata_x <= op2_d;  // Store data
    targ_x  <= targ_d;
  end

  // ==============================
  // Execute, memory, writeback
  // ==============================

  assign result_x    = ctrl.mul_sel ? op1_x * op2_x : op1_x + op2_x;
  assign status.eq_x = (op1_x == op2_x);
  assign status.inst_d = inst_d;

  always_ff @(posedge clk) begin
    result_m <= result_x;
    sdata_m  <= sdata_x;
  end

  assign dmem_req.val   = ctrl.dmem_val;
  assign dmem_req.wr    = ctrl.dmem_wr;
  assign dmem_req.addr  = result_m;
  assign dmem_req.wdata = sdata_m;

  assign wb_m = ctrl.wb_mem ? dmem_rdata : result_m;

  always_ff @(posedge clk) begin
    wb_w <= wb_m;
  end

  assign rf_wen   = ctrl.rf_wen;
  assign rf_waddr = ctrl.rf_waddr;
  assign rf_wdata = wb_w;

endmodule

`default_nettype wire

// ==== hdl/proc_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module proc_top #(
  parameter tinyrv1_pkg::word_t RESET_PC = 32'h0000_0200
) (
  input  wire                       clk,
  input  wire                       reset,
  output tinyrv1_pkg::word_t        imem_addr,
  input  wire tinyrv1_pkg::word_t   imem_data,
  output tinyrv1_pkg::dmem_req_t    dmem_req,
  input  wire tinyrv1_pkg::word_t   dmem_rdata
);
  import tinyrv1_pkg::*;

  ctrl_t     ctrl;
  status_t   status;
  reg_addr_t rf_raddr1;
  reg_addr_t rf_raddr2;
  word_t     rf_rdata1;
  word_t     rf_rdata2;
  logic      rf_wen;
  reg_addr_t rf_waddr;
  word_t     rf_wdata;

  // ==============================
  // Core blocks
  // ==============================

  proc_ctrl ctrl_unit (
    .clk    (clk),
    .reset  (reset),
    .status (status),
    .ctrl   (ctrl)
  );

  proc_dpath #(
    .RESET_PC (RESET_PC)
  ) dpath (
    .clk        (clk),
    .reset      (reset),
    .ctrl       (ctrl),
    .status     (status),
    .imem_addr  (imem_addr),
    .imem_data  (imem_data),
    .dmem_req   (dmem_req),
    .dmem_rdata (dmem_rdata),
    .rf_raddr1  (rf_raddr1),
    .rf_raddr2  (rf_raddr2),
    .rf_rdata1  (rf_rdata1),
    .rf_rdata2  (rf_rdata2),
    .rf_wen     (rf_wen),
    .rf_waddr   (rf_waddr),
    .rf_wdata   (rf_wdata)
  );

  reg_file rf (
    .clk    (clk),
    .reset  (reset),
    .raddr1 (rf_raddr1),
    .raddr2 (rf_raddr2),
    .rdata1 (rf_rdata1),
    .rdata2 (rf_rdata2),
    .wen    (rf_wen),
    .waddr  (rf_waddr),
    .wdata  (rf_wdata)
  );

endmodule

`default_nettype wire

// ==== hdl/reg_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module reg_file (
  input  wire                         clk,
  input  wire                         reset,
  input  wire tinyrv1_pkg::reg_addr_t raddr1,
  input  wire tinyrv1_pkg::reg_addr_t raddr2,
  output tinyrv1_pkg::word_t          rdata1,
  output tinyrv1_pkg::word_t          rdata2,
  input  wire                         wen,
  input  wire tinyrv1_pkg::reg_addr_t waddr,
  input  wire tinyrv1_pkg::word_t     wdata
);
  import tinyrv1_pkg::*;

  word_t regs [32];

  always_ff @(posedge clk) begin
    if (!reset && wen && waddr != '0) regs[waddr] <= wdata;  // x0 never stored
  end

  // Write-through so W and D can share a cycle
  assign rdata1 = (raddr1 == '0) ? '0 : (wen && waddr == raddr1) ? wdata : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : (wen && waddr == raddr2) ? wdata : regs[raddr2];

  // Storage behind x0 stays untouched by its writes
  x0_stays_zero: assert property (@(posedge clk) disable iff (reset)
    (wen && waddr == '0) |=> $stable(regs[0]));

endmodule

`default_nettype wire

// ==== hdl/tinyrv1_pkg.sv ====
`default_nettype none

package tinyrv1_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;

  // ==============================
  // Encodings
  // ==============================

  typedef enum logic [3:0] {
    OP_NOP,  // All-zero bubble or anything unsupported
    OP_ADD,
    OP_ADDI,
    OP_MUL,
    OP_LW,
    OP_SW,
    OP_JAL,
    OP_JR,
    OP_BNE
  } op_e;

  typedef enum logic [1:0] {PC_PLUS4, PC_JAL, PC_JR, PC_BR} pc_sel_e;
  typedef enum logic [1:0] {BYP_RF, BYP_X, BYP_M, BYP_W} byp_sel_e;
  typedef enum logic [1:0] {IMM_I, IMM_S, IMM_J, IMM_B} imm_type_e;

  // ==============================
  // Control and status bundles
  // ==============================

  typedef struct packed {
    logic      reg_en_f;
    logic      reg_en_d;
    logic      squash_d;   // Zero goes into the D register
    pc_sel_e   pc_sel;
    imm_type_e imm_type;
    byp_sel_e  op1_byp;
    byp_sel_e  op2_byp;
    logic      op2_imm;
    logic      mul_sel;    // X stage
    logic      dmem_val;   // M stage
    logic      dmem_wr;
    logic      wb_mem;
    logic      rf_wen;     // W stage
    reg_addr_t rf_waddr;
  } ctrl_t;

  typedef struct packed {
    word_t inst_d;
    logic  eq_x;
  } status_t;

  typedef struct packed {
    logic  val;
    logic  wr;
    word_t addr;
    word_t wdata;
  } dmem_req_t;

  // Opcode, funct3 and funct7 matching
  function automatic op_e decode_op(word_t inst);
    casez (inst)
      32'b0000000_?????_?????_000_?????_0110011: return OP_ADD;
      32'b0000001_?????_?????_000_?????_0110011: return OP_MUL;
      32'b???????_?????_?????_000_?????_0010011: return OP_ADDI;
      32'b???????_?????_?????_010_?????_0000011: return OP_LW;
      32'b???????_?????_?????_010_?????_0100011: return OP_SW;
      32'b???????_?????_?????_???_?????_1101111: return OP_JAL;
      32'b???????_?????_?????_000_00000_1100111: return OP_JR;
      32'b???????_?????_?????_001_?????_1100011: return OP_BNE;
      default:                                   return OP_NOP;
    endcase
  endfunction

  function automatic reg_addr_t rs1_of(word_t inst);
    return inst[19:15];
  endfunction

  function automatic reg_addr_t rs2_of(word_t inst);
    return inst[24:20];
  endfunction

  function automatic reg_addr_t rd_of(word_t inst);
    return inst[11:7];
  endfunction

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build the TinyRV1 core testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module proc_tb -o proc_tb_sim

./obj_dir/proc_tb_sim | tee sim.log

if grep -q "Regression passed" sim.log; then
  exit 0
else
  exit 1
fi

// ==== src.f ====
+incdir+verification
hdl/tinyrv1_pkg.sv
hdl/reg_file.sv
hdl/proc_ctrl.sv
hdl/proc_dpath.sv
hdl/proc_top.sv
verification/proc_tb.sv

// ==== verification/proc_tb_checks.svh ====
`ifndef PROC_TB_CHECKS_SVH
`define PROC_TB_CHECKS_SVH

// Data memory request as seen at a store edge
task automatic check_req(input string what, input dmem_req_t got, input dmem_req_t exp);
  if (got !== exp) begin
    $display("[FAIL] %0t %s: got %0b/%0b/%h/%h, expected %0b/%0b/%h/%h (val/wr/addr/wdata)",
             $time, what, got.val, got.wr, got.addr, got.wdata,
             exp.val, exp.wr, exp.addr, exp.wdata);
    test_errs++;
  end
endtask

// Plain 32-bit word for memory contents and the fetch address
task automatic check_word(input string what, input word_t got, input word_t exp);
  if (got !== exp) begin
    $display("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp);
    test_errs++;
  end
endtask

`endif

// ==== verification/proc_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module proc_tb;
  import tinyrv1_pkg::*;

  localparam word_t RESET_PC = 32'h0000_0200;
  localparam int    N_TESTS  = 5;
  localparam int    MAX_INST = 12;
  localparam int    MAX_ST   = 4;
  localparam int    LIMIT    = N_TESTS * MAX_INST * 4 + 50;  // Cycles for the whole run

  logic      clk;
  logic      reset;
  word_t     imem_addr;
  word_t     imem_data;
  word_t     imem_off;
  dmem_req_t dmem_req;
  word_t     dmem_rdata;

  word_t     imem [16];
  word_t     dmem [256];
  word_t     dmem_init [256];
  dmem_req_t obs_q [$];  // Stores in the order they hit memory

  string     test_name [N_TESTS];
  word_t     prog [N_TESTS][MAX_INST];
  dmem_req_t exp_st [N_TESTS][MAX_ST];
  int        exp_cnt [N_TESTS];

  int cycles = 0;
  int test_errs;
  int pass_cnt = 0;
  int fail_cnt = 0;

  `include "proc_tb_checks.svh"

  proc_top #(
    .RESET_PC (RESET_PC)
  ) dut (
    .clk        (clk),
    .reset      (reset),
    .imem_addr  (imem_addr),
    .imem_data  (imem_data),
    .dmem_req   (dmem_req),
    .dmem_rdata (dmem_rdata)
  );

  // ==============================
  // Clock, memories, watchdog
  // ==============================

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always_comb begin
    imem_off  = imem_addr - RESET_PC;
    imem_data = (imem_off < 32'd64) ? imem[imem_off[5:2]] : '0;  // Past the program reads NOP
  end

  assign dmem_rdata = reset ? '0 : dmem[dmem_req.addr[9:2]];

  // Image reload during reset and stores on the edge
  always @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 256; i++) dmem[i] <= dmem_init[i];
      obs_q.delete();
    end else if (dmem_req.val && dmem_req.wr) begin
      dmem[dmem_req.addr[9:2]] <= dmem_req.wdata;
      obs_q.push_back(dmem_req);
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      $display("Timeout after %0d cycles, the program table did not complete", cycles);
      $display("Regression failed");
      $finish;
    end
  end

  // ==============================
  // Instruction encoders
  // ==============================

  function automatic word_t add(int rd, int rs1, int rs2);
    return {7'b0000000, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], 7'b0110011};
  endfunction

  function automatic word_t mul(int rd, int rs1, int rs2);
    return {7'b0000001, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], 7'b0110011};
  endfunction

  function automatic word_t addi(int rd, int rs1, int imm);
    return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
  endfunction

  function automatic word_t lw(int rd, int rs1, int imm);
    return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
  endfunction

  function automatic word_t sw(int rs2, int rs1, int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic word_t jal(int rd, int off);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
  endfunction

  function automatic word_t jr(int rs1);
    return {12'd0, rs1[4:0], 3'b000, 5'd0, 7'b1100111};
  endfunction

  function automatic word_t bne(int rs1, int rs2, int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], 3'b001, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic dmem_req_t wr_req(word_t addr, word_t data);
    return '{val: 1'b1, wr: 1'b1, addr: addr, wdata: data};
  endfunction

  function automatic word_t mem_at(word_t addr);
    return dmem_init[addr[9:2]];
  endfunction

  // ==============================
  // Program table
  // ==============================

  task automatic load_table();
    test_name[0] = "alu_forwarding";
    prog[0]    = '{addi(2, 0, 7), addi(3, 2, 5), add(4, 3, 2),  // X then X and M
                   mul(5, 4, 3), addi(1, 0, 256), add(6, 5, 2),
                   sw(4, 1, 0), sw(5, 1, 4), mul(7, 6, 6),       // W into MUL
                   sw(6, 1, 8), sw(7, 1, 12), 32'h0};
    exp_cnt[0] = 4;
    exp_st[0]  = '{wr_req(32'h100, 7 + 5 + 7), wr_req(32'h104, (7 + 5 + 7) * (7 + 5)),
                   wr_req(32'h108, 19 * 12 + 7), wr_req(32'h10c, 235 * 235)};

    test_name[1] = "load_use";
    prog[1]    = '{addi(1, 0, 128), addi(8, 0, 256), lw(2, 1, 0),
                   addi(3, 2, 5), lw(4, 1, 4), add(5, 4, 3),     // Both uses stall
                   sw(3, 8, 0), sw(5, 8, 4), lw(6, 8, 0),
                   sw(6, 8, 8), 32'h0, 32'h0};                     // Store data stalls too
    exp_cnt[1] = 3;
    exp_st[1]  = '{wr_req(32'h100, mem_at(32'h80) + 5),
                   wr_req(32'h104, mem_at(32'h84) + mem_at(32'h80) + 5),
                   wr_req(32'h108, mem_at(32'h80) + 5), '0};

    test_name[2] = "jal_jr";
    prog[2]    = '{addi(8, 0, 256), jal(1, 12), sw(8, 8, 64),
                   sw(8, 8, 68), sw(1, 8, 0), addi(2, 0, RESET_PC + 36),
                   jr(2), sw(8, 8, 72), sw(8, 8, 76),
                   addi(3, 1, 1), sw(3, 8, 4), 32'h0};
    exp_cnt[2] = 2;
    exp_st[2]  = '{wr_req(32'h100, RESET_PC + 4 + 4), wr_req(32'h104, RESET_PC + 8 + 1),
                   '0, '0};

    test_name[3] = "bne";
    prog[3]    = '{addi(8, 0, 256), addi(1, 0, 5), addi(2, 0, 5),
                   bne(1, 2, 12), sw(1, 8, 0), addi(2, 2, 1),    // Falls through
                   bne(1, 2, 12), sw(1, 8, 4), sw(2, 8, 8),      // Both squashed
                   add(3, 1, 2), sw(3, 8, 12), 32'h0};
    exp_cnt[3] = 2;
    exp_st[3]  = '{wr_req(32'h100, 5), wr_req(32'h10c, 5 + 6), '0, '0};

    test_name[4] = "x0_writes";
    prog[4]    = '{addi(8, 0, 256), addi(0, 0, 55), add(1, 0, 0),
                   sw(0, 8, 0), addi(2, 0, 9), mul(0, 2, 2),
                   addi(3, 0, 1), lw(0, 0, 128), add(4, 0, 3),
                   sw(1, 8, 4), sw(4, 8, 8), sw(0, 8, 12)};
    exp_cnt[4] = 4;
    exp_st[4]  = '{wr_req(32'h100, 0), wr_req(32'h104, 0), wr_req(32'h108, 0 + 1),
                   wr_req(32'h10c, 0)};
  endtask

  // ==============================
  // Test sequence
  // ==============================

  task automatic run_test(input int t);
    int waited;
    @(posedge clk);
    for (int i = 0; i < 16; i++) imem[i] <= '0;
    for (int i = 0; i < MAX_INST; i++) imem[i] <= prog[t][i];
    reset <= 1'b1;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    test_errs = 0;
    waited = 0;
    @(negedge clk);
    check_word("imem_addr", imem_addr, RESET_PC);  // First fetch after reset
    while (obs_q.size() < exp_cnt[t] && waited < MAX_INST * 4) begin
      @(negedge clk);
      waited++;
    end
    repeat (6) @(negedge clk);  // Room for any stray store
    if (obs_q.size() != exp_cnt[t]) begin
      $display("Test %s saw %0d stores within %0d cycles where %0d were expected",
               test_name[t], obs_q.size(), waited, exp_cnt[t]);
      test_errs++;
    end
    for (int i = 0; i < exp_cnt[t] && i < obs_q.size(); i++) begin
      check_req($sformatf("dmem_req store %0d", i), obs_q[i], exp_st[t][i]);
      check_word($sformatf("dmem[%h]", exp_st[t][i].addr),
                 dmem[exp_st[t][i].addr[9:2]], exp_st[t][i].wdata);
    end
    if (test_errs == 0) begin
      $display("PASS %s", test_name[t]);
      pass_cnt++;
    end else begin
      $display("FAIL %s with %0d errors", test_name[t], test_errs);
      fail_cnt++;
    end
  endtask

  initial begin
    reset <= 1'b1;
    for (int i = 0; i < 16; i++) imem[i] <= '0;
    void'($urandom(73955));
    for (int i = 0; i < 256; i++) dmem_init[i] = $urandom;
    load_table();
    for (int t = 0; t < N_TESTS; t++) run_test(t);
    $display("Summary: %0d tests, %0d passed, %0d failed", N_TESTS, pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
